/* bench/rep_det_top_tb.sv */
`timescale 1ns/1ns
`include "vchess_macros.svh"

module rep_det_top_tb
   import vchess_pkg::*;
();

   localparam int CLK_PERIOD  = 4;
   localparam int N_QUERIES   = 24;
   localparam int WDOG_CYCLES = N_QUERIES * `REPDET_COUNT + 3000;  // Pushes and abort wait in margin

   logic                           clk;
   logic                           arst_n;
   board_t                         push_board, board_0, board_1;
   castle_t                        push_castle, castle_0, castle_1;
   logic                           push_valid, pop_valid, clear_history;
   logic                           query_0_valid, query_1_valid, abort_0, abort_1;
   logic                           rep_0, rep_0_valid, rep_1, rep_1_valid, history_full;
   logic [`REPDET_DEPTH_WIDTH-1:0] history_depth;

   entry_t                         ref_hist [0:`REPDET_COUNT-1];  // Mirror of game history
   logic [`REPDET_DEPTH_WIDTH-1:0] ref_depth;
   board_t                         pool [0:3];    // Few boards, repeats likely
   logic [15:0]                    lfsr = 16'd65;
   int                             errors = 0;
   int                             checks = 0;

   rep_det_top rep_det_top_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // Galois LFSR, one step per bit taken
   function logic random_bit();
      logic b;
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
      return b;
   endfunction

   function board_t random_board();
      board_t b;
      b = '0;
      repeat (`BOARD_WIDTH)
         b = {b[`BOARD_WIDTH-2:0], random_bit()};
      return b;
   endfunction

   // Two or more exact matches at same side to move, below the depth
   function logic expect_rep(input board_t b, input castle_t c);
      int n;
      n = 0;
      for (int i = int'(ref_depth) - 2; i >= 0; i -= 2)
         if (ref_hist[hist_addr_t'(i)] == {c, b})
            n++;
      return n >= 2;
   endfunction

   task fail_value(input string name, input int got, input int exp);
      errors++;
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
   endtask

   task fail_text(input string msg);
      errors++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   // One cycle on the history inputs, reference updated alongside
   task history_op(input logic push, input logic pop, input logic clr,
                   input board_t b, input castle_t c);
      @(posedge clk);
      {push_valid, pop_valid, clear_history} <= {push, pop, clr};
      push_board  <= b;
      push_castle <= c;
      @(posedge clk);
      {push_valid, pop_valid, clear_history} <= 3'b000;
      if (clr)                                         // Clear first
         ref_depth = '0;
      else if (push && int'(ref_depth) < `REPDET_COUNT)
      begin
         ref_hist[ref_depth[`REPDET_WIDTH-1:0]] = {c, b};
         ref_depth = ref_depth + 1'b1;
      end
      else if (pop && ref_depth != '0)                 // Pop at zero ignored
         ref_depth = ref_depth - 1'b1;
   endtask

   task push_pos(input board_t b, input castle_t c);
      history_op(1'b1, 1'b0, 1'b0, b, c);
   endtask

   task pop_pos();
      history_op(1'b0, 1'b1, 1'b0, '0, '0);
   endtask

   task clear_hist();
      history_op(1'b0, 1'b0, 1'b1, '0, '0);
   endtask

   task check_depth();
      @(negedge clk);  // Mid-cycle, outputs settled
      checks++;
      if (history_depth !== ref_depth)
         fail_value("history_depth", int'(history_depth), int'(ref_depth));
      if (history_full !== (int'(ref_depth) == `REPDET_COUNT))
         fail_value("history_full", int'(history_full), int'(int'(ref_depth) == `REPDET_COUNT));
   endtask

   task port_result(input int port, input logic wanted, input logic got, input logic exp,
                    input int cycles);
      checks++;
      if (!wanted)
         fail_text($sformatf("unexpected rep_%0d_valid pulse", port));
      else if (got !== exp)
         fail_value($sformatf("rep_%0d", port), int'(got), int'(exp));
      else if (int'(ref_depth) < 2 && cycles != 2)  // Short history has fixed latency
         fail_value($sformatf("rep_%0d_valid latency", port), cycles, 2);
   endtask

   // Start one or both ports in the same cycle, wait for each pulse
   task run_query(input logic en0, input board_t b0, input castle_t c0,
                  input logic en1, input board_t b1, input castle_t c1);
      logic exp0;
      logic exp1;
      logic got0;
      logic got1;
      int   cycles;
      exp0 = expect_rep(b0, c0);
      exp1 = expect_rep(b1, c1);
      got0 = !en0;  // Idle port counts as done
      got1 = !en1;
      @(posedge clk);
      {query_0_valid, board_0, castle_0} <= {en0, b0, c0};
      {query_1_valid, board_1, castle_1} <= {en1, b1, c1};
      @(posedge clk);
      query_0_valid <= 1'b0;
      query_1_valid <= 1'b0;
      for (cycles = 1; cycles < `REPDET_COUNT + 8 && !(got0 && got1); cycles++)
      begin
         @(negedge clk);
         if (rep_0_valid)
         begin
            port_result(0, !got0, rep_0, exp0, cycles);
            got0 = 1'b1;
         end
         if (rep_1_valid)
         begin
            port_result(1, !got1, rep_1, exp1, cycles);
            got1 = 1'b1;
         end
      end
      if (!got0)
         fail_text("no rep_0_valid pulse after query_0_valid");
      if (!got1)
         fail_text("no rep_1_valid pulse after query_1_valid");
   endtask

   // Abort a long scan on port 0, no pulse may follow
   task run_abort(input board_t b, input castle_t c);
      @(posedge clk);
      {query_0_valid, board_0, castle_0} <= {1'b1, b, c};
      @(posedge clk);
      query_0_valid <= 1'b0;
      repeat (6) @(posedge clk);  // Scan well under way
      abort_0 <= 1'b1;
      @(posedge clk);
      abort_0 <= 1'b0;
      checks++;
      repeat (2 * `REPDET_COUNT)
      begin
         @(negedge clk);
         if (rep_0_valid)
            fail_text("rep_0_valid pulsed after abort_0");
      end
   endtask

   task test_short();
      run_query(1'b1, pool[0], 4'hF, 1'b1, pool[1], 4'hF);  // Empty history
      push_pos(pool[0], 4'hF);
      check_depth();
      run_query(1'b1, pool[0], 4'hF, 1'b0, pool[1], 4'hF);  // Depth 1
      pop_pos();
      check_depth();
      pop_pos();                                            // Stays at 0
      check_depth();
   endtask

   // A at plies 0 and 2, B only on odd plies
   task test_repeat();
      clear_hist();
      push_pos(pool[0], 4'hF);
      push_pos(pool[1], 4'hF);
      push_pos(pool[0], 4'hF);
      push_pos(pool[1], 4'hF);
      run_query(1'b1, pool[0], 4'hF, 1'b1, pool[1], 4'hF);
      run_query(1'b0, pool[0], 4'hF, 1'b1, pool[0], 4'h7);  // Castle mask differs
      push_pos(pool[2], 4'hF);
      push_pos(pool[3], 4'hF);
      run_query(1'b1, pool[2], 4'hF, 1'b0, pool[0], 4'hF);  // One earlier copy only
   endtask

   task test_pop();
      clear_hist();
      push_pos(pool[2], 4'hF);
      push_pos(pool[3], 4'hF);
      push_pos(pool[0], 4'hF);
      push_pos(pool[1], 4'hF);
      push_pos(pool[0], 4'hF);
      push_pos(pool[3], 4'hF);
      run_query(1'b1, pool[0], 4'hF, 1'b0, pool[0], 4'hF);  // Plies 4 and 2 match
      pop_pos();
      pop_pos();                                            // Ply 4 gone
      check_depth();
      run_query(1'b1, pool[0], 4'hF, 1'b0, pool[0], 4'hF);
   endtask

   task test_dual();
      logic [1:0] i0;
      logic [1:0] i1;
      int         n;
      repeat (8)
      begin
         clear_hist();
         n = 2 + int'({random_bit(), random_bit(), random_bit(), random_bit()});
         repeat (n)
         begin
            i0 = {random_bit(), random_bit()};
            push_pos(pool[i0], random_bit() ? 4'hF : 4'h3);
         end
         i0 = {random_bit(), random_bit()};
         i1 = i0 + {1'b0, random_bit()} + 2'd1;  // Never the port 0 board
         run_query(1'b1, pool[i0], random_bit() ? 4'hF : 4'h3,
                   1'b1, pool[i1], random_bit() ? 4'hF : 4'h3);
      end
   endtask

   task test_full();
      clear_hist();
      push_pos(pool[0], 4'hF);
      push_pos(pool[1], 4'hF);
      push_pos(pool[0], 4'hF);
      repeat (`REPDET_COUNT - 3)
         push_pos(random_board(), 4'hF);
      check_depth();
      push_pos(pool[2], 4'hF);  // Table full, dropped
      check_depth();
      run_abort(random_board(), 4'hF);
      run_query(1'b1, pool[0], 4'hF, 1'b1, pool[1], 4'hF);  // Full length scans
      clear_hist();
      check_depth();
   endtask

   initial
   begin
      arst_n = 1'b0;
      {push_board, board_0, board_1} = '0;
      {push_castle, castle_0, castle_1} = '0;
      {push_valid, pop_valid, clear_history} = 3'b000;
      {query_0_valid, query_1_valid, abort_0, abort_1} = 4'b0000;
      ref_depth = '0;
      pool[0] = random_board();
      pool[1] = random_board();
      pool[2] = random_board();
      pool[3] = random_board();
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      check_depth();
      if (rep_0_valid !== 1'b0 || rep_1_valid !== 1'b0 || rep_0 !== 1'b0 || rep_1 !== 1'b0)
         fail_text("result outputs not low after reset");
      test_short();
      test_repeat();
      test_pop();
      test_dual();
      test_full();
      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin
      #(WDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, tests did not finish", WDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* hw/rep_det.sv */
`timescale 1ns/1ns
`include "vchess_macros.svh"

module rep_det
   import vchess_pkg::*;
(
   input  logic                           clk,
   input  logic                           arst_n,

   // Query port 0
   input  board_t                         board_0,
   input  castle_t                        castle_0,
   input  logic                           board_0_valid,
   input  logic                           clear_repdet_0,

   // Query port 1
   input  board_t                         board_1,
   input  castle_t                        castle_1,
   input  logic                           board_1_valid,
   input  logic                           clear_repdet_1,

   // History writes
   input  board_t                         wr_board,
   input  castle_t                        wr_castle,
   input  hist_addr_t                     wr_addr,
   input  logic                           wr_en,
   input  logic [`REPDET_DEPTH_WIDTH-1:0] depth_in,

   output logic                           board_0_three_move_rep,
   output logic                           board_0_three_move_rep_valid,
   output logic                           board_1_three_move_rep,
   output logic                           board_1_three_move_rep_valid
);

   entry_t     hist_mem [0:`REPDET_COUNT-1];  // One write, two reads, maps to block RAM
   entry_t     rd_entry_0;
   entry_t     rd_entry_1;
   hist_addr_t rd_addr_0;
   hist_addr_t rd_addr_1;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         hist_mem[wr_addr] <= {wr_castle, wr_board};
      // Registered reads, data one cycle after address
      rd_entry_0 <= hist_mem[rd_addr_0];
      rd_entry_1 <= hist_mem[rd_addr_1];
   end

   rep_det_sub rep_det_sub_0 (
      .clk                  (clk),
      .arst_n               (arst_n),
      .board_in             (board_0),
      .castle_in            (castle_0),
      .board_valid          (board_0_valid),
      .clear_repdet         (clear_repdet_0),
      .depth_in             (depth_in),
      .rd_addr              (rd_addr_0),
      .rd_entry             (rd_entry_0),
      .three_move_rep       (board_0_three_move_rep),
      .three_move_rep_valid (board_0_three_move_rep_valid)
   );

   rep_det_sub rep_det_sub_1 (
      .clk                  (clk),
      .arst_n               (arst_n),
      .board_in             (board_1),
      .castle_in            (castle_1),
      .board_valid          (board_1_valid),
      .clear_repdet         (clear_repdet_1),
      .depth_in             (depth_in),
      .rd_addr              (rd_addr_1),
      .rd_entry             (rd_entry_1),
      .three_move_rep       (board_1_three_move_rep),
      .three_move_rep_valid (board_1_three_move_rep_valid)
   );

endmodule

/* hw/rep_det_sub.sv */
`timescale 1ns/1ns
`include "vchess_macros.svh"

module rep_det_sub
   import vchess_pkg::*;
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  board_t                         board_in,
   input  castle_t                        castle_in,
   input  logic                           board_valid,   // Start or restart a query
   input  logic                           clear_repdet,  // Abort, no result
   input  logic [`REPDET_DEPTH_WIDTH-1:0] depth_in,
   output hist_addr_t                     rd_addr,
   input  entry_t                         rd_entry,      // Table word for last cycle's rd_addr
   output logic                           three_move_rep,
   output logic                           three_move_rep_valid
);

   scan_state_t                    state;
   entry_t                         cand;        // Latched candidate
   logic [`REPDET_DEPTH_WIDTH-1:0] depth_q;     // Latched ply count
   hist_addr_t                     addr_q;      // Address being read this cycle
   logic                           live_q;      // rd_entry belongs to the current scan
   logic                           report_q;    // Cleared by abort
   logic [1:0]                     cnt;         // Matches so far, saturates at 2
   logic [1:0]                     cnt_next;
   logic                           hit;
   logic                           stop_early;
   logic                           last_addr;
   logic                           short_hist;
   logic [`REPDET_DEPTH_WIDTH-1:0] start_addr;

   assign rd_addr = addr_q;

   // Same side to move sits two plies back
   assign start_addr = depth_in - 2'd2;
   assign short_hist = (depth_in[`REPDET_DEPTH_WIDTH-1:1] == '0);  // Depth 0 or 1

   // Compare on the cycle the registered read returns
   assign hit        = live_q && (rd_entry == cand);
   assign cnt_next   = (cnt == 2'd2) ? 2'd2 : cnt + {1'b0, hit};
   assign stop_early = (cnt_next == 2'd2);
   assign last_addr  = (addr_q[`REPDET_WIDTH-1:1] == '0);  // Address 0 or 1

   // Query snapshot
   always_ff @(posedge clk)
   begin
      if (board_valid)
      begin
         cand    <= {castle_in, board_in};
         depth_q <= depth_in;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state                <= S_IDLE;
         addr_q               <= '0;
         live_q               <= 1'b0;
         report_q             <= 1'b0;
         cnt                  <= 2'd0;
         three_move_rep       <= 1'b0;
         three_move_rep_valid <= 1'b0;
      end
      else
      begin
         three_move_rep_valid <= 1'b0;  // Pulse by default
         if (clear_repdet)
         begin
            // Any read still in flight is untagged and ignored
            live_q   <= 1'b0;
            report_q <= 1'b0;
            state    <= (state == S_IDLE) ? S_IDLE : S_DRAIN;
         end
         else if (board_valid)
         begin
            addr_q   <= start_addr[`REPDET_WIDTH-1:0];
            live_q   <= 1'b0;       // Drop reads of an older scan
            report_q <= 1'b1;
            cnt      <= 2'd0;
            state    <= short_hist ? S_DONE : S_SCAN;
         end
         else
         begin
            case (state)
               S_SCAN:
               begin
                  cnt    <= cnt_next;
                  live_q <= !stop_early;  // Current address only counts if scan goes on
                  if (stop_early || last_addr)
                     state <= S_DRAIN;
                  else
                     addr_q <= addr_q - 2'd2;
               end
               S_DRAIN:
               begin
                  cnt    <= cnt_next;
                  live_q <= 1'b0;
                  state  <= report_q ? S_DONE : S_IDLE;
               end
               S_DONE:
               begin
                  three_move_rep       <= (cnt == 2'd2);
                  three_move_rep_valid <= 1'b1;
                  state                <= S_IDLE;
               end
               default:
                  state <= S_IDLE;
            endcase
         end
      end
   end

   // Result never stretches past one cycle
   a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      three_move_rep_valid |=> !three_move_rep_valid);

   // Scan stays strictly below the depth seen at query time
   a_addr_bound: assert property (@(posedge clk) disable iff (!arst_n)
      (state == S_SCAN) |-> ({1'b0, rd_addr} < depth_q));

endmodule

/* hw/rep_det_top.sv */
`timescale 1ns/1ns
`include "vchess_macros.svh"

module rep_det_top
   import vchess_pkg::*;
(
   input  logic                           clk,
   input  logic                           arst_n,

   // History control
   input  board_t                         push_board,
   input  castle_t                        push_castle,
   input  logic                           push_valid,
   input  logic                           pop_valid,
   input  logic                           clear_history,

   // Query port 0
   input  board_t                         board_0,
   input  castle_t                        castle_0,
   input  logic                           query_0_valid,
   input  logic                           abort_0,

   // Query port 1
   input  board_t                         board_1,
   input  castle_t                        castle_1,
   input  logic                           query_1_valid,
   input  logic                           abort_1,

   output logic                           rep_0,
   output logic                           rep_0_valid,
   output logic                           rep_1,
   output logic                           rep_1_valid,
   output logic [`REPDET_DEPTH_WIDTH-1:0] history_depth,
   output logic                           history_full
);

   board_t     wr_board;
   castle_t    wr_castle;
   hist_addr_t wr_addr;
   logic       wr_en;

   repdet_history repdet_history_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .push_board    (push_board),
      .push_castle   (push_castle),
      .push_valid    (push_valid),
      .pop_valid     (pop_valid),
      .clear_history (clear_history),
      .wr_board      (wr_board),
      .wr_castle     (wr_castle),
      .wr_addr       (wr_addr),
      .wr_en         (wr_en),
      .depth         (history_depth),
      .full          (history_full)
   );

   // Both scanners see the same live depth
   rep_det rep_det_i (
      .clk                          (clk),
      .arst_n                       (arst_n),
      .board_0                      (board_0),
      .castle_0                     (castle_0),
      .board_0_valid                (query_0_valid),
      .clear_repdet_0               (abort_0),
      .board_1                      (board_1),
      .castle_1                     (castle_1),
      .board_1_valid                (query_1_valid),
      .clear_repdet_1               (abort_1),
      .wr_board                     (wr_board),
      .wr_castle                    (wr_castle),
      .wr_addr                      (wr_addr),
      .wr_en                        (wr_en),
      .depth_in                     (history_depth),
      .board_0_three_move_rep       (rep_0),
      .board_0_three_move_rep_valid (rep_0_valid),
      .board_1_three_move_rep       (rep_1),
      .board_1_three_move_rep_valid (rep_1_valid)
   );

endmodule

/* hw/repdet_history.sv */
`timescale 1ns/1ns
`include "vchess_macros.svh"

module repdet_history
   import vchess_pkg::*;
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  board_t                         push_board,
   input  castle_t                        push_castle,
   input  logic                           push_valid,     // Move played
   input  logic                           pop_valid,      // Move taken back
   input  logic                           clear_history,  // New game
   output board_t                         wr_board,
   output castle_t                        wr_castle,
   output hist_addr_t                     wr_addr,
   output logic                           wr_en,
   output logic [`REPDET_DEPTH_WIDTH-1:0] depth,          // Plies in the table
   output logic                           full
);

   logic do_push;

   assign full = (depth == `REPDET_COUNT);

   // Clear beats push, push into a full table is dropped
   assign do_push = push_valid && !clear_history && !full;

   // New entry lands at the current depth in this cycle
   assign wr_en     = do_push;
   assign wr_addr   = depth[`REPDET_WIDTH-1:0];
   assign wr_board  = push_board;
   assign wr_castle = push_castle;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         depth <= '0;
      else if (clear_history)
         depth <= '0;
      else if (push_valid)
      begin
         if (!full)
            depth <= depth + 1'b1;
      end
      else if (pop_valid && (depth != '0))  // Pop at zero is a no-op
         depth <= depth - 1'b1;
   end

   // Counter never runs past table size
   a_depth_bound: assert property (@(posedge clk) disable iff (!arst_n)
      depth <= `REPDET_COUNT);

endmodule

/* hw/vchess_macros.svh */
`ifndef VCHESS_MACROS_SVH
`define VCHESS_MACROS_SVH

// Packed board, 64 squares of 4 bits each
`define BOARD_WIDTH 256

// One rights bit per rook
`define CASTLE_WIDTH 4

// Table word holds castle mask above board
`define ENTRY_WIDTH (`BOARD_WIDTH + `CASTLE_WIDTH)

// History address bits
`define REPDET_WIDTH 7
`define REPDET_COUNT (1 << `REPDET_WIDTH)

// Depth reaches REPDET_COUNT when full, so one extra bit
`define REPDET_DEPTH_WIDTH (`REPDET_WIDTH + 1)

`endif

/* hw/vchess_pkg.sv */
`include "vchess_macros.svh"

package vchess_pkg;

   // Full board, compared bit for bit
   typedef logic [`BOARD_WIDTH-1:0] board_t;

   // KQkq rights
   typedef logic [`CASTLE_WIDTH-1:0] castle_t;

   // {castle, board} as stored in the history table
   typedef logic [`ENTRY_WIDTH-1:0] entry_t;

   // History table index
   typedef logic [`REPDET_WIDTH-1:0] hist_addr_t;

   // Scanner control
   typedef enum logic [1:0] {
      S_IDLE,
      S_SCAN,   // One read issued per cycle
      S_DRAIN,  // Last read retires
      S_DONE    // Result goes out next edge
   } scan_state_t;

endpackage

/* rep_det_top.f */
+incdir+hw
hw/vchess_pkg.sv
hw/repdet_history.sv
hw/rep_det_sub.sv
hw/rep_det.sv
hw/rep_det_top.sv
bench/rep_det_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module rep_det_top_tb \
   -f rep_det_top.f -o rep_det_top_sim > build.log 2>&1 \
   && ./obj_dir/rep_det_top_sim > sim.log 2>&1 \
   && grep -q "^RESULT: PASS$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
